//--- hdl/demosaic_pkg.sv
package demosaic_pkg;

	// --------------------------------------------------
	// sizes
	// --------------------------------------------------
	localparam int pixel_width    = 12;  // raw sample and colour channel
	localparam int line_addr_bits = 11;  // up to 2048 pixels per line
	localparam int num_lines      = 3;
	localparam int pipe_latency   = 5;   // sync_in to sync_out

	// --------------------------------------------------
	// stream types
	// --------------------------------------------------
	typedef logic [pixel_width-1:0] pixel_t;

	typedef struct packed {
		logic vs;
		logic hs;
		logic de;
	} sync_t;

	// r in the top bits
	typedef struct packed {
		pixel_t r;
		pixel_t g;
		pixel_t b;
	} rgb_t;

	// 3x3 neighbourhood, row then column, p11 is the centre
	typedef struct packed {
		pixel_t p00, p01, p02;
		pixel_t p10, p11, p12;
		pixel_t p20, p21, p22;
	} window_t;

	typedef struct packed {
		logic y_odd;
		logic x_odd;
	} phase_t;

	// colour order of the top-left 2x2 block
	typedef logic [1:0] pattern_t;
	localparam pattern_t pat_gr = 2'd0;
	localparam pattern_t pat_rg = 2'd1;
	localparam pattern_t pat_bg = 2'd2;
	localparam pattern_t pat_gb = 2'd3;

endpackage

//--- hdl/line_buffer.sv
`timescale 1ns/10ps

module line_buffer (
	input  logic                                    clk,
	input  logic                                    wr_en,
	input  logic [demosaic_pkg::line_addr_bits-1:0] wr_addr,
	input  demosaic_pkg::pixel_t                    wr_data,
	input  logic [demosaic_pkg::line_addr_bits-1:0] rd_addr,
	output demosaic_pkg::pixel_t                    rd_data
);
	import demosaic_pkg::*;

	// one video line, simple dual port
	pixel_t mem [2**line_addr_bits];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// registered read, one cycle
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- hdl/line_writer.sv
`timescale 1ns/10ps

module line_writer (
	input  logic                                    clk,
	input  logic                                    reset,
	input  demosaic_pkg::sync_t                     sync_in,
	input  demosaic_pkg::pixel_t                    data_in,
	output logic [demosaic_pkg::num_lines-1:0]      wr_en,
	output logic [demosaic_pkg::line_addr_bits-1:0] wr_addr,
	output logic [demosaic_pkg::line_addr_bits-1:0] rd_addr,
	output demosaic_pkg::pixel_t                    wr_data,
	output logic [1:0]                              newest_line,
	output logic                                    y_odd,
	output demosaic_pkg::sync_t                     sync_d,
	output demosaic_pkg::pixel_t                    pixel_d
);
	import demosaic_pkg::*;

	logic [line_addr_bits:0] col;  // spare top bit flags an overlong line
	logic [1:0]              line_idx;
	logic                    row_odd;  // parity of the newest row
	logic                    line_end;

	// --------------------------------------------------
	// input register
	// --------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			sync_d <= '0;
		else
			sync_d <= sync_in;
	end

	always_ff @(posedge clk)
	begin
		pixel_d <= data_in;
	end

	// last registered pixel of the line
	assign line_end = sync_d.de & ~sync_in.de;

	// --------------------------------------------------
	// column count and line rotation
	// --------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			col      <= '0;
			line_idx <= '0;
			row_odd  <= 1'b0;
		end
		else if (sync_d.vs)
		begin
			col      <= '0;
			line_idx <= '0;
			row_odd  <= 1'b0;
		end
		else if (line_end)
		begin
			col      <= '0;
			line_idx <= (line_idx == 2'(num_lines - 1)) ? 2'd0 : line_idx + 2'd1;
			row_odd  <= ~row_odd;
		end
		else if (sync_d.de)
			col <= col + 1'b1;
	end

	assign wr_en       = sync_d.de ? (num_lines'(1) << line_idx) : '0;
	assign wr_addr     = col[line_addr_bits-1:0];
	assign rd_addr     = col[line_addr_bits-1:0];  // older lines, same column
	assign wr_data     = pixel_d;
	assign newest_line = line_idx;
	assign y_odd       = ~row_odd;  // centre sits one row above the newest

	a_wr_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(wr_en));

	a_col_range: assert property (@(posedge clk) disable iff (reset)
		col < (1 << line_addr_bits));

endmodule

//--- hdl/window_assembler.sv
`timescale 1ns/10ps

module window_assembler (
	input  logic                                         clk,
	input  logic                                         reset,
	input  demosaic_pkg::pattern_t                       bayer_pattern,
	input  demosaic_pkg::pixel_t [demosaic_pkg::num_lines-1:0] rd_data,
	input  demosaic_pkg::pixel_t                         pixel_d,
	input  logic [1:0]                                   newest_line,
	input  logic                                         y_odd,
	input  demosaic_pkg::sync_t                          sync_d,
	output demosaic_pkg::window_t                        window,
	output demosaic_pkg::phase_t                         phase,
	output demosaic_pkg::sync_t                          sync_w
);
	import demosaic_pkg::*;

	pixel_t     pixel_a;  // newest row, lined up with rd_data
	logic [1:0] line_a;
	logic       y_a;
	sync_t      sync_a;
	logic       col_odd;  // parity of the column arriving now
	pixel_t     row_top;
	pixel_t     row_mid;
	phase_t     flip;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			line_a  <= '0;
			y_a     <= 1'b0;
			sync_a  <= '0;
			col_odd <= 1'b0;
		end
		else
		begin
			line_a  <= newest_line;
			y_a     <= y_odd;
			sync_a  <= sync_d;
			col_odd <= sync_a.de ? ~col_odd : 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		pixel_a <= pixel_d;
	end

	// previous line is the middle row, the one before it the top
	always_comb
	begin
		case (line_a)
			2'd0:
			begin
				row_top = rd_data[1];
				row_mid = rd_data[2];
			end
			2'd1:
			begin
				row_top = rd_data[2];
				row_mid = rd_data[0];
			end
			default:
			begin
				row_top = rd_data[0];
				row_mid = rd_data[1];
			end
		endcase
	end

	// move the R site to phase 00 for every order
	always_comb
	begin
		case (bayer_pattern)
			pat_gr:  flip = 2'b01;
			pat_rg:  flip = 2'b00;
			pat_bg:  flip = 2'b11;
			pat_gb:  flip = 2'b10;
			default: flip = 2'b00;
		endcase
	end

	// --------------------------------------------------
	// column shift, oldest column on the left
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		window.p00 <= window.p01;
		window.p01 <= window.p02;
		window.p02 <= row_top;
		window.p10 <= window.p11;
		window.p11 <= window.p12;
		window.p12 <= row_mid;
		window.p20 <= window.p21;
		window.p21 <= window.p22;
		window.p22 <= pixel_a;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			phase  <= '0;
			sync_w <= '0;
		end
		else
		begin
			phase.y_odd <= y_a ^ flip.y_odd;
			phase.x_odd <= ~col_odd ^ flip.x_odd;  // centre is one column back
			sync_w      <= sync_a;
		end
	end

endmodule

//--- hdl/demosaic_interp.sv
`timescale 1ns/10ps

module demosaic_interp (
	input  logic                  clk,
	input  logic                  reset,
	input  demosaic_pkg::window_t window,
	input  demosaic_pkg::phase_t  phase,
	input  demosaic_pkg::sync_t   sync_w,
	output demosaic_pkg::sync_t   sync_out,
	output demosaic_pkg::rgb_t    data_out
);
	import demosaic_pkg::*;

	typedef logic [pixel_width+1:0] sum_t;  // room for four samples

	typedef struct packed {
		sum_t   edge_sum;    // up, down, left, right
		sum_t   corner_sum;
		sum_t   horiz_sum;
		sum_t   vert_sum;
		pixel_t centre;
	} sums_t;

	sums_t  s1;
	phase_t phase_1;
	sync_t  sync_1;
	rgb_t   rgb_2;

	// --------------------------------------------------
	// stage 1: neighbour sums
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		s1.edge_sum   <= sum_t'(window.p01) + sum_t'(window.p10)
		               + sum_t'(window.p12) + sum_t'(window.p21);
		s1.corner_sum <= sum_t'(window.p00) + sum_t'(window.p02)
		               + sum_t'(window.p20) + sum_t'(window.p22);
		s1.horiz_sum  <= sum_t'(window.p10) + sum_t'(window.p12);
		s1.vert_sum   <= sum_t'(window.p01) + sum_t'(window.p21);
		s1.centre     <= window.p11;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			phase_1 <= '0;
			sync_1  <= '0;
		end
		else
		begin
			phase_1 <= phase;
			sync_1  <= sync_w;
		end
	end

	// --------------------------------------------------
	// stage 2: pick per site, truncate
	// --------------------------------------------------
	always_comb
	begin
		case (phase_1)
			2'b00:  // R site
			begin
				rgb_2.r = s1.centre;
				rgb_2.g = s1.edge_sum[pixel_width+1:2];
				rgb_2.b = s1.corner_sum[pixel_width+1:2];
			end
			2'b11:  // B site
			begin
				rgb_2.r = s1.corner_sum[pixel_width+1:2];
				rgb_2.g = s1.edge_sum[pixel_width+1:2];
				rgb_2.b = s1.centre;
			end
			2'b01:  // G between R neighbours
			begin
				rgb_2.r = s1.horiz_sum[pixel_width:1];
				rgb_2.g = s1.centre;
				rgb_2.b = s1.vert_sum[pixel_width:1];
			end
			default:  // G on a B row
			begin
				rgb_2.r = s1.vert_sum[pixel_width:1];
				rgb_2.g = s1.centre;
				rgb_2.b = s1.horiz_sum[pixel_width:1];
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			sync_out <= '0;
			data_out <= '0;
		end
		else
		begin
			sync_out <= sync_1;
			data_out <= rgb_2;
		end
	end

	a_de_delay: assert property (@(posedge clk) disable iff (reset)
		sync_out.de == $past(sync_w.de, 2));

endmodule

//--- hdl/bayer_demosaic_top.sv
`timescale 1ns/10ps

module bayer_demosaic_top (
	input  logic                   clk,
	input  logic                   reset,
	input  demosaic_pkg::sync_t    sync_in,
	input  demosaic_pkg::pixel_t   data_in,
	input  demosaic_pkg::pattern_t bayer_pattern,  // change only while vs is high
	output demosaic_pkg::sync_t    sync_out,
	output demosaic_pkg::rgb_t     data_out
);
	import demosaic_pkg::*;

	logic [num_lines-1:0]      wr_en;
	logic [line_addr_bits-1:0] wr_addr;
	logic [line_addr_bits-1:0] rd_addr;
	pixel_t                    wr_data;
	logic [1:0]                newest_line;
	logic                      y_odd;
	sync_t                     sync_d;
	pixel_t                    pixel_d;
	pixel_t [num_lines-1:0]    rd_data;
	window_t                   window;
	phase_t                    phase;
	sync_t                     sync_w;

	line_writer u_writer (
		.clk         (clk),
		.reset       (reset),
		.sync_in     (sync_in),
		.data_in     (data_in),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.rd_addr     (rd_addr),
		.wr_data     (wr_data),
		.newest_line (newest_line),
		.y_odd       (y_odd),
		.sync_d      (sync_d),
		.pixel_d     (pixel_d)
	);

	// rolling buffer, one RAM per line
	for (genvar i = 0; i < num_lines; i++)
	begin : g_line
		line_buffer u_buf (
			.clk     (clk),
			.wr_en   (wr_en[i]),
			.wr_addr (wr_addr),
			.wr_data (wr_data),
			.rd_addr (rd_addr),
			.rd_data (rd_data[i])
		);
	end

	window_assembler u_window (
		.clk           (clk),
		.reset         (reset),
		.bayer_pattern (bayer_pattern),
		.rd_data       (rd_data),
		.pixel_d       (pixel_d),
		.newest_line   (newest_line),
		.y_odd         (y_odd),
		.sync_d        (sync_d),
		.window        (window),
		.phase         (phase),
		.sync_w        (sync_w)
	);

	demosaic_interp u_interp (
		.clk      (clk),
		.reset    (reset),
		.window   (window),
		.phase    (phase),
		.sync_w   (sync_w),
		.sync_out (sync_out),
		.data_out (data_out)
	);

	// strobes come out a fixed number of cycles after they go in
	a_sync_latency: assert property (@(posedge clk) disable iff (reset)
		$past(!reset, pipe_latency) |-> sync_out == $past(sync_in, pipe_latency));

endmodule

//--- dv/bayer_checker.sv
`timescale 1ns/10ps

module bayer_checker (
	input  logic                clk,
	input  logic                reset,
	input  demosaic_pkg::sync_t sync_in,
	input  demosaic_pkg::sync_t sync_out,
	input  demosaic_pkg::rgb_t  data_out,
	output int                  checks,
	output int                  errors,
	output int                  frames_done
);
	import demosaic_pkg::*;

	localparam int mem_words   = 1024;
	localparam int max_frames  = 16;
	localparam int site_r      = 0;
	localparam int site_g_rrow = 1;  // green between two reds
	localparam int site_g_brow = 2;
	localparam int site_b      = 3;

	logic [15:0] stim [mem_words];
	int          frame_base [max_frames];
	sync_t       sync_hist [pipe_latency];  // input strobes, newest first
	int          check_cnt = 0;
	int          error_cnt = 0;
	int          done_cnt  = 0;
	int          out_frame;
	int          out_row;
	int          out_col;
	logic        vs_prev;
	logic        de_prev;
	logic        strobe_seen;  // first strobe has reached the output

	assign checks      = check_cnt;
	assign errors      = error_cnt;
	assign frames_done = done_cnt;

	initial
	begin
		int base;
		$readmemh("dv/frames_input.txt", stim);
		base = 0;
		for (int f = 0; f < max_frames; f++)
		begin
			frame_base[f] = base;
			if (stim[base+1] != 0)
				base = base + 3 + stim[base+1] * stim[base+2];
		end
	end

	function automatic int raw_pixel(input int f, input int y, input int x);
		int w;
		w = stim[frame_base[f] + 1];
		return stim[frame_base[f] + 3 + y * w + x];
	endfunction

	// colour of a site, from the top-left 2x2 block of each order
	function automatic int site_of(input int pattern, input int y, input int x);
		int sites [4];  // (0,0) (0,1) (1,0) (1,1)
		case (pattern)
			0:       sites = '{site_g_rrow, site_r, site_b, site_g_brow};  // G R / B G
			1:       sites = '{site_r, site_g_rrow, site_g_brow, site_b};  // R G / G B
			2:       sites = '{site_b, site_g_brow, site_g_rrow, site_r};  // B G / G R
			default: sites = '{site_g_brow, site_b, site_r, site_g_rrow};  // G B / R G
		endcase
		return sites[(y % 2) * 2 + (x % 2)];
	endfunction

	// --------------------------------------------------
	// bilinear model, low bits dropped
	// --------------------------------------------------
	function automatic rgb_t expected_rgb(input int f, input int y, input int x);
		int   centre;
		int   horiz;
		int   vert;
		int   edges;
		int   corners;
		rgb_t px;
		centre  = raw_pixel(f, y, x);
		horiz   = (raw_pixel(f, y, x - 1) + raw_pixel(f, y, x + 1)) / 2;
		vert    = (raw_pixel(f, y - 1, x) + raw_pixel(f, y + 1, x)) / 2;
		edges   = (raw_pixel(f, y - 1, x) + raw_pixel(f, y + 1, x)
		         + raw_pixel(f, y, x - 1) + raw_pixel(f, y, x + 1)) / 4;
		corners = (raw_pixel(f, y - 1, x - 1) + raw_pixel(f, y - 1, x + 1)
		         + raw_pixel(f, y + 1, x - 1) + raw_pixel(f, y + 1, x + 1)) / 4;
		case (site_of(stim[frame_base[f]], y, x))
			site_r:
			begin
				px.r = pixel_t'(centre);
				px.g = pixel_t'(edges);
				px.b = pixel_t'(corners);
			end
			site_b:
			begin
				px.r = pixel_t'(corners);
				px.g = pixel_t'(edges);
				px.b = pixel_t'(centre);
			end
			site_g_rrow:
			begin
				px.r = pixel_t'(horiz);
				px.g = pixel_t'(centre);
				px.b = pixel_t'(vert);
			end
			default:
			begin
				px.r = pixel_t'(vert);
				px.g = pixel_t'(centre);
				px.b = pixel_t'(horiz);
			end
		endcase
		return px;
	endfunction

	// outputs settle well before the falling edge
	always @(negedge clk)
	begin
		int   w;
		int   h;
		rgb_t exp_rgb;
		if (reset)
		begin
			if (sync_out !== '0 || data_out !== '0)
			begin
				$display("FAILED sync_out/data_out in reset: expected 0x0/0x0, got 0x%h/0x%h",
					sync_out, data_out);
				error_cnt++;
			end
			foreach (sync_hist[i])
				sync_hist[i] = '0;
			out_frame   = -1;
			out_row     = 0;
			out_col     = 0;
			vs_prev     = 1'b0;
			de_prev     = 1'b0;
			strobe_seen = 1'b0;
		end
		else
		begin
			if (sync_out !== sync_hist[pipe_latency-1])
			begin
				$display("FAILED sync_out: expected 0x%h, got 0x%h",
					sync_hist[pipe_latency-1], sync_out);
				error_cnt++;
			end
			for (int i = pipe_latency - 1; i > 0; i--)
				sync_hist[i] = sync_hist[i-1];
			sync_hist[0] = sync_in;

			// data stays zero until the first strobe comes out
			if (sync_out !== '0)
				strobe_seen = 1'b1;
			else if (!strobe_seen && data_out !== '0)
			begin
				$display("FAILED data_out after reset: expected 0x0, got 0x%h", data_out);
				error_cnt++;
			end

			if (sync_out.vs && !vs_prev)  // new frame on the output
			begin
				out_frame++;
				out_row = 0;
				out_col = 0;
			end
			w = 0;
			h = 0;
			if (out_frame >= 0 && out_frame < max_frames)
			begin
				w = stim[frame_base[out_frame] + 1];
				h = stim[frame_base[out_frame] + 2];
			end

			if (sync_out.de)
			begin
				if (out_frame < 0)
				begin
					$display("de_out went high before the first frame start");
					error_cnt++;
				end
				else if (out_row >= 2 && out_row <= h - 1 && out_col >= 2 && out_col <= w - 1)
				begin
					exp_rgb = expected_rgb(out_frame, out_row - 1, out_col - 1);
					check_cnt++;
					if (data_out !== exp_rgb)
					begin
						$display("FAILED data_out frame %0d centre (%0d,%0d): expected 0x%h, got 0x%h",
							out_frame, out_row - 1, out_col - 1, exp_rgb, data_out);
						error_cnt++;
					end
				end
				out_col++;
			end
			else if (de_prev)  // end of an output line
			begin
				if (out_col != w)
				begin
					$display("FAILED de_count frame %0d row %0d: expected 0x%h, got 0x%h",
						out_frame, out_row, w, out_col);
					error_cnt++;
				end
				out_row++;
				out_col = 0;
				if (out_row == h)
					done_cnt++;
			end
			vs_prev = sync_out.vs;
			de_prev = sync_out.de;
		end
	end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/10ps

module tb_top;
	import demosaic_pkg::*;

	localparam int mem_words   = 1024;
	localparam int max_frames  = 16;
	localparam int out_timeout = 400;  // cycles for one frame to drain

	logic        clk;
	logic        reset;
	sync_t       sync_in;
	pixel_t      data_in;
	pattern_t    bayer_pattern;
	sync_t       sync_out;
	rgb_t        data_out;
	int          checks;
	int          errors;
	int          frames_done;
	logic [15:0] stim [mem_words];
	int          frame_pass;
	int          frame_fail;
	bit          timed_out;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	bayer_demosaic_top u_dut (
		.clk           (clk),
		.reset         (reset),
		.sync_in       (sync_in),
		.data_in       (data_in),
		.bayer_pattern (bayer_pattern),
		.sync_out      (sync_out),
		.data_out      (data_out)
	);

	bayer_checker u_check (
		.clk         (clk),
		.reset       (reset),
		.sync_in     (sync_in),
		.sync_out    (sync_out),
		.data_out    (data_out),
		.checks      (checks),
		.errors      (errors),
		.frames_done (frames_done)
	);

	// inputs move 2 ns after the rising edge
	task automatic drive_cycle(input logic vs, input logic hs, input logic de, input pixel_t pix);
		@(posedge clk);
		#2;
		sync_in.vs = vs;
		sync_in.hs = hs;
		sync_in.de = de;
		data_in    = pix;
	endtask

	task automatic send_frame(input int base);
		int width;
		int height;
		int gap;
		width  = stim[base+1];
		height = stim[base+2];
		drive_cycle(1'b1, 1'b0, 1'b0, '0);
		bayer_pattern = pattern_t'(stim[base]);  // vs is high here
		repeat (3) drive_cycle(1'b1, 1'b0, 1'b0, '0);
		repeat (2) drive_cycle(1'b0, 1'b0, 1'b0, '0);
		for (int y = 0; y < height; y++)
		begin
			for (int x = 0; x < width; x++)
				drive_cycle(1'b0, 1'b0, 1'b1, pixel_t'(stim[base + 3 + y * width + x]));
			gap = 2 + int'($urandom % 5);
			drive_cycle(1'b0, 1'b1, 1'b0, '0);  // hs at the start of blanking
			repeat (gap - 1) drive_cycle(1'b0, 1'b0, 1'b0, '0);
		end
	endtask

	task automatic wait_frame_out(input int count, output bit ok);
		int n;
		n = 0;
		while (frames_done < count && n < out_timeout)
		begin
			@(posedge clk);
			n++;
		end
		ok = (frames_done >= count);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial
	begin
		int base;
		int nframes;
		int err_start;
		int chk_start;
		int frame_errs;
		int frame_chks;
		bit ok;
		reset         = 1'b1;
		sync_in       = '0;
		data_in       = '0;
		bayer_pattern = pat_gr;
		frame_pass    = 0;
		frame_fail    = 0;
		timed_out     = 1'b0;
		void'($urandom(32'h4a5c));
		$readmemh("dv/frames_input.txt", stim);
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;

		base    = 0;
		nframes = 0;
		while (nframes < max_frames && stim[base+1] != 0)
		begin
			err_start = errors;
			chk_start = checks;
			send_frame(base);
			wait_frame_out(nframes + 1, ok);
			if (!ok)
			begin
				$display("timeout: frame %0d did not leave the DUT within %0d cycles",
					nframes, out_timeout);
				timed_out = 1'b1;
				break;
			end
			frame_errs = errors - err_start;
			frame_chks = checks - chk_start;
			if (frame_errs == 0 && frame_chks > 0)
				frame_pass++;
			else
				frame_fail++;
			$display("frame %0d order %0d %0dx%0d: %0d pixels checked, %0d errors, %s",
				nframes, stim[base], stim[base+1], stim[base+2], frame_chks, frame_errs,
				(frame_errs == 0 && frame_chks > 0) ? "pass" : "fail");
			base = base + 3 + stim[base+1] * stim[base+2];
			nframes++;
		end
		repeat (4) drive_cycle(1'b0, 1'b0, 1'b0, '0);

		$display("summary: %0d frames passed, %0d frames failed, %0d checker errors",
			frame_pass, frame_fail, errors);
		if (!timed_out && nframes > 0 && frame_fail == 0 && errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- dv/frames_input.txt
// Bayer test frames, every value in hex
// header line: pattern (0 GR, 1 RG, 2 BG, 3 GB), width, height; then one line of raw pixels per row
// frame 0, GR
0 8 7
1a3 7f2 0c4 9e1 3b7 fff 250 6d8
8c0 045 ffe 312 a9b 5c6 0e7 d41
2f9 b38 671 ffd 0a2 c55 4e3 91f
e07 36c 9a4 1d8 fff 7b0 ff0 058
4c2 d9e 083 a6f 52b 0f1 c3a 2e6
7d5 119 f4c 6a0 b82 fe9 39d 860
0b3 c7a 5e8 243 9f6 1c4 a71 e2d
// frame 1, RG
1 6 6
301 c5a 78e 0f2 e49 5b7
a16 2d3 fff ffe 6c0 1e8
5f4 e82 fff fff 0d5 93b
0c9 7a1 fff fff b4e 27c
d60 48f 13a 9e5 f07 6b2
82b 0e4 c9d 35a 7f1 a08
// frame 2, BG
2 a 6
111 222 333 444 555 666 777 888 999 aaa
0f0 f0f 0f0 f0f 0f0 f0f 0f0 f0f 0f0 f0f
6a7 1b4 c83 3e9 f12 8d5 27c a60 4f1 d3e
9c2 e57 0ab 72d 1f8 b46 e93 05c 8a7 36f
2d8 8f3 5b1 c04 69e 0e2 b7d 4a9 f35 1c6
e41 3a6 9d0 17b a85 f2c 04e 6b3 c19 7e4
// frame 3, GB
3 7 7
5a1 0e3 b72 48d f16 2c9 964
c3b 7f0 13e e85 6d2 a47 0b9
28e d14 fa9 3c6 871 05b e20
9f3 46a 0d7 b5c 2e1 c8f 73a
e6d 1b8 83f 5a2 f04 6c7 a91
04c a25 6e1 ff8 39b d70 15e
7b6 ec2 2a0 91d 0f5 48b c33
// end marker, width zero
0 0 0

//--- src.f
hdl/demosaic_pkg.sv
hdl/line_buffer.sv
hdl/line_writer.sv
hdl/window_assembler.sv
hdl/demosaic_interp.sv
hdl/bayer_demosaic_top.sv
dv/bayer_checker.sv
dv/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build the demosaic testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_top -Mdir obj_dir -f src.f \
	&& ./obj_dir/Vtb_top 2>&1 | tee sim.log \
	|| { echo "simulation did not run to completion"; exit 1; }
grep -q "Regression failed" sim.log && { echo "FAIL"; exit 1; } \
	|| { echo "PASS"; exit 0; }
